/* hdl/armlite_defs.svh */
`ifndef ARMLITE_DEFS_SVH
`define ARMLITE_DEFS_SVH

`define ARMLITE_DATA_W          32
`define ARMLITE_INTAKE_DEPTH    4
`define ARMLITE_RESULT_DEPTH    4
`define ARMLITE_RESULT_CREDITS  4

// Instruction word fields with bit 31 unused
`define ARMLITE_F_OP        30:28
`define ARMLITE_F_SETFLAGS  27
`define ARMLITE_F_IMMSEL    26
`define ARMLITE_F_SHIFT     25:24
`define ARMLITE_F_SHAMT     23:20
`define ARMLITE_F_RN        19:16
`define ARMLITE_F_RD        15:12
`define ARMLITE_F_RM        3:0
`define ARMLITE_F_IMM       11:0
`define ARMLITE_IMM_W       12

`endif

/* hdl/armlitePkg.sv */
package armlitePkg;

  // ALU operations encoded as instruction bits 30..28
  typedef enum logic [2:0] {
    OP_AND = 3'd0,
    OP_EOR = 3'd1,
    OP_SUB = 3'd2,
    OP_ADD = 3'd3,
    OP_ORR = 3'd4,
    OP_MOV = 3'd5,
    OP_MVN = 3'd6,
    OP_CMP = 3'd7
  } aluOp_t;

  // Barrel shifter modes for operand B
  typedef enum logic [1:0] {
    SH_LSL = 2'd0,
    SH_LSR = 2'd1,
    SH_ASR = 2'd2,
    SH_ROR = 2'd3
  } shiftOp_t;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flags_t;

  typedef logic [3:0] regIdx_t;

endpackage

/* hdl/instrIntake.sv */
`timescale 1ns/10ps
`include "armlite_defs.svh"

module instrIntake import armlitePkg::*; (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       instrValid,
  input  logic [`ARMLITE_DATA_W-1:0] instr,
  input  logic                       advance,
  output logic                       instrCredit,
  output logic                       decValid,
  output aluOp_t                     decOp,
  output logic                       decSetFlags,
  output logic                       decImm,
  output shiftOp_t                   decShift,
  output logic [3:0]                 decShamt,
  output regIdx_t                    decRn,
  output regIdx_t                    decRd,
  output regIdx_t                    decRm,
  output logic [`ARMLITE_DATA_W-1:0] decImmValue
);
  localparam int W = `ARMLITE_DATA_W;
  localparam int Depth = `ARMLITE_INTAKE_DEPTH;
  localparam int PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CntW = $clog2(Depth + 1);

  logic [W-1:0]    fifoMem [Depth];
  logic [PtrW-1:0] wrPtr;
  logic [PtrW-1:0] rdPtr;
  logic [CntW-1:0] count;
  logic [W-1:0]    head;
  logic            pop;

  assign decValid = (count != '0);
  assign pop = advance && decValid;

  always_ff @(posedge clk) begin
    if (instrValid) begin
      fifoMem[wrPtr] <= instr;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
      instrCredit <= 1'b0;
    end else begin
      if (instrValid) begin
        wrPtr <= (wrPtr == PtrW'(Depth - 1)) ? '0 : wrPtr + 1'b1;
      end
      if (pop) begin
        rdPtr <= (rdPtr == PtrW'(Depth - 1)) ? '0 : rdPtr + 1'b1;
      end
      case ({instrValid, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // One credit back to the sender per entry that leaves
      instrCredit <= pop;
    end
  end

  // Field split of the head entry
  assign head = fifoMem[rdPtr];
  assign decOp = aluOp_t'(head[`ARMLITE_F_OP]);
  assign decSetFlags = head[`ARMLITE_F_SETFLAGS];
  assign decImm = head[`ARMLITE_F_IMMSEL];
  assign decShift = shiftOp_t'(head[`ARMLITE_F_SHIFT]);
  assign decShamt = head[`ARMLITE_F_SHAMT];
  assign decRn = head[`ARMLITE_F_RN];
  assign decRd = head[`ARMLITE_F_RD];
  assign decRm = head[`ARMLITE_F_RM];
  assign decImmValue = {{(W - `ARMLITE_IMM_W){1'b0}}, head[`ARMLITE_F_IMM]};

endmodule

/* hdl/regFile.sv */
`timescale 1ns/10ps
`include "armlite_defs.svh"

module regFile import armlitePkg::*; (
  input  logic                       clk,
  input  regIdx_t                    ra1,
  input  regIdx_t                    ra2,
  output logic [`ARMLITE_DATA_W-1:0] rd1,
  output logic [`ARMLITE_DATA_W-1:0] rd2,
  input  logic                       we,
  input  regIdx_t                    wa,
  input  logic [`ARMLITE_DATA_W-1:0] wd,
  input  logic                       reset
);
  localparam int W = `ARMLITE_DATA_W;

  logic [W-1:0] regs [16];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 16; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[wa] <= wd;
    end
  end

  // Write-through so decode sees the value being written back
  assign rd1 = (we && wa == ra1) ? wd : regs[ra1];
  assign rd2 = (we && wa == ra2) ? wd : regs[ra2];

endmodule

/* hdl/executeStage.sv */
`timescale 1ns/10ps
`include "armlite_defs.svh"

module executeStage import armlitePkg::*; (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       advance,
  input  logic                       decValid,
  input  aluOp_t                     decOp,
  input  logic                       decSetFlags,
  input  logic                       decImm,
  input  shiftOp_t                   decShift,
  input  logic [3:0]                 decShamt,
  input  regIdx_t                    decRn,
  input  regIdx_t                    decRd,
  input  regIdx_t                    decRm,
  input  logic [`ARMLITE_DATA_W-1:0] decImmValue,
  input  logic [`ARMLITE_DATA_W-1:0] rd1,
  input  logic [`ARMLITE_DATA_W-1:0] rd2,
  output logic                       wbValid,
  output logic [`ARMLITE_DATA_W-1:0] wbData,
  output regIdx_t                    wbReg,
  output logic                       wbWrote,
  output flags_t                     wbFlags
);
  localparam int W = `ARMLITE_DATA_W;

  // Decode-to-execute register
  logic         exValid;
  aluOp_t       exOp;
  logic         exSetFlags;
  logic         exImm;
  shiftOp_t     exShift;
  logic [3:0]   exShamt;
  regIdx_t      exRn;
  regIdx_t      exRd;
  regIdx_t      exRm;
  logic [W-1:0] exImmValue;
  logic [W-1:0] exRnVal;
  logic [W-1:0] exRmVal;

  flags_t       flagsQ;
  flags_t       flagsNext;
  logic [W-1:0] srcA;
  logic [W-1:0] srcM;
  logic [W:0]   shiftWide;
  logic [W-1:0] opB;
  logic         shiftCarry;
  logic [W:0]   sumWide;
  logic [W-1:0] aluOut;
  logic         updateFlags;

  always_ff @(posedge clk) begin
    if (reset) begin
      exValid <= 1'b0;
    end else if (advance) begin
      exValid <= decValid;
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      exOp <= decOp;
      exSetFlags <= decSetFlags;
      exImm <= decImm;
      exShift <= decShift;
      exShamt <= decShamt;
      exRn <= decRn;
      exRd <= decRd;
      exRm <= decRm;
      exImmValue <= decImmValue;
      exRnVal <= rd1;
      exRmVal <= rd2;
    end
  end

  // Forward from writeback when it targets our source
  assign srcA = (wbValid && wbWrote && wbReg == exRn) ? wbData : exRnVal;
  assign srcM = (wbValid && wbWrote && wbReg == exRm) ? wbData : exRmVal;

  // Barrel shifter on operand B
  always_comb begin
    shiftWide = '0;
    opB = srcM;
    shiftCarry = flagsQ.c;
    if (exImm) begin
      opB = exImmValue;
    end else if (exShamt != 4'd0) begin
      case (exShift)
        SH_LSL: begin
          shiftWide = {1'b0, srcM} << exShamt;
          opB = shiftWide[W-1:0];
          shiftCarry = shiftWide[W];
        end
        SH_LSR: begin
          shiftWide = {srcM, 1'b0} >> exShamt;
          opB = shiftWide[W:1];
          shiftCarry = shiftWide[0];
        end
        SH_ASR: begin
          shiftWide = $signed({srcM, 1'b0}) >>> exShamt;
          opB = shiftWide[W:1];
          shiftCarry = shiftWide[0];
        end
        default: begin
          opB = (srcM >> exShamt) | (srcM << (W - int'(exShamt)));
          // Last bit rotated out lands in the top bit
          shiftCarry = opB[W-1];
        end
      endcase
    end
  end

  // ALU and flag generation
  always_comb begin
    sumWide = '0;
    flagsNext = flagsQ;
    flagsNext.c = shiftCarry;
    case (exOp)
      OP_AND: aluOut = srcA & opB;
      OP_EOR: aluOut = srcA ^ opB;
      OP_ORR: aluOut = srcA | opB;
      OP_MVN: aluOut = ~opB;
      OP_ADD: begin
        sumWide = {1'b0, srcA} + {1'b0, opB};
        aluOut = sumWide[W-1:0];
        flagsNext.c = sumWide[W];
        flagsNext.v = (srcA[W-1] == opB[W-1]) && (aluOut[W-1] != srcA[W-1]);
      end
      OP_SUB, OP_CMP: begin
        // Carry set means no borrow
        sumWide = {1'b0, srcA} + {1'b0, ~opB} + 1'b1;
        aluOut = sumWide[W-1:0];
        flagsNext.c = sumWide[W];
        flagsNext.v = (srcA[W-1] != opB[W-1]) && (aluOut[W-1] != srcA[W-1]);
      end
      default: aluOut = opB;
    endcase
    flagsNext.n = aluOut[W-1];
    flagsNext.z = (aluOut == '0);
  end

  assign updateFlags = exValid && (exSetFlags || exOp == OP_CMP);

  // Execute-to-writeback register and flags
  always_ff @(posedge clk) begin
    if (reset) begin
      wbValid <= 1'b0;
      wbWrote <= 1'b0;
      flagsQ <= '0;
    end else if (advance) begin
      wbValid <= exValid;
      wbWrote <= exValid && (exOp != OP_CMP);
      if (updateFlags) begin
        flagsQ <= flagsNext;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      wbData <= aluOut;
      wbReg <= exRd;
      wbFlags <= updateFlags ? flagsNext : flagsQ;
    end
  end

endmodule

/* hdl/resultPort.sv */
`timescale 1ns/10ps
`include "armlite_defs.svh"

module resultPort import armlitePkg::*; (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       wbValid,
  input  logic [`ARMLITE_DATA_W-1:0] wbData,
  input  regIdx_t                    wbReg,
  input  logic                       wbWrote,
  input  flags_t                     wbFlags,
  input  logic                       resultCredit,
  output logic                       advance,
  output logic                       resultValid,
  output logic [`ARMLITE_DATA_W-1:0] resultData,
  output regIdx_t                    resultReg,
  output logic                       resultWrote,
  output flags_t                     resultFlags
);
  localparam int W = `ARMLITE_DATA_W;
  localparam int Depth = `ARMLITE_RESULT_DEPTH;
  localparam int PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CntW = $clog2(Depth + 1);
  localparam int CreditW = $clog2(`ARMLITE_RESULT_CREDITS + 1);

  logic [W-1:0]       qData [Depth];
  regIdx_t            qReg [Depth];
  logic               qWrote [Depth];
  flags_t             qFlags [Depth];
  logic [PtrW-1:0]    wrPtr;
  logic [PtrW-1:0]    rdPtr;
  logic [CntW-1:0]    count;
  logic [CreditW-1:0] credits;
  logic               push;
  logic               send;

  // Room for both records still in execute and writeback
  assign advance = (Depth - int'(count)) >= 2;
  assign push = wbValid && advance;
  assign send = (count != '0) && (credits != '0);

  always_ff @(posedge clk) begin
    if (push) begin
      qData[wrPtr] <= wbData;
      qReg[wrPtr] <= wbReg;
      qWrote[wrPtr] <= wbWrote;
      qFlags[wrPtr] <= wbFlags;
    end
    if (send) begin
      resultData <= qData[rdPtr];
      resultReg <= qReg[rdPtr];
      resultWrote <= qWrote[rdPtr];
      resultFlags <= qFlags[rdPtr];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
      credits <= CreditW'(`ARMLITE_RESULT_CREDITS);
      resultValid <= 1'b0;
    end else begin
      if (push) begin
        wrPtr <= (wrPtr == PtrW'(Depth - 1)) ? '0 : wrPtr + 1'b1;
      end
      if (send) begin
        rdPtr <= (rdPtr == PtrW'(Depth - 1)) ? '0 : rdPtr + 1'b1;
      end
      case ({push, send})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // Returned credit and spent credit cancel out
      case ({resultCredit, send})
        2'b10:   credits <= credits + 1'b1;
        2'b01:   credits <= credits - 1'b1;
        default: credits <= credits;
      endcase
      resultValid <= send;
    end
  end

endmodule

/* hdl/armliteCore.sv */
`timescale 1ns/10ps
`include "armlite_defs.svh"

module armliteCore import armlitePkg::*; (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       instrValid,
  input  logic [`ARMLITE_DATA_W-1:0] instr,
  output logic                       instrCredit,
  output logic                       resultValid,
  output logic [`ARMLITE_DATA_W-1:0] resultData,
  output regIdx_t                    resultReg,
  output logic                       resultWrote,
  output flags_t                     resultFlags,
  input  logic                       resultCredit
);
  localparam int W = `ARMLITE_DATA_W;

  logic         advance;

  // Decoded head of the intake FIFO
  logic         decValid;
  aluOp_t       decOp;
  logic         decSetFlags;
  logic         decImm;
  shiftOp_t     decShift;
  logic [3:0]   decShamt;
  regIdx_t      decRn;
  regIdx_t      decRd;
  regIdx_t      decRm;
  logic [W-1:0] decImmValue;
  logic [W-1:0] rd1;
  logic [W-1:0] rd2;

  // Writeback stage
  logic         wbValid;
  logic [W-1:0] wbData;
  regIdx_t      wbReg;
  logic         wbWrote;
  flags_t       wbFlags;

  instrIntake i_intake (
    .clk(clk), .reset(reset), .instrValid(instrValid), .instr(instr),
    .advance(advance), .instrCredit(instrCredit), .decValid(decValid),
    .decOp(decOp), .decSetFlags(decSetFlags), .decImm(decImm), .decShift(decShift),
    .decShamt(decShamt), .decRn(decRn), .decRd(decRd), .decRm(decRm),
    .decImmValue(decImmValue)
  );

  // Writes only carry instructions that target a register
  regFile i_regFile (
    .clk(clk), .ra1(decRn), .ra2(decRm), .rd1(rd1), .rd2(rd2),
    .we(wbWrote), .wa(wbReg), .wd(wbData), .reset(reset)
  );

  executeStage i_execute (
    .clk(clk), .reset(reset), .advance(advance), .decValid(decValid),
    .decOp(decOp), .decSetFlags(decSetFlags), .decImm(decImm), .decShift(decShift),
    .decShamt(decShamt), .decRn(decRn), .decRd(decRd), .decRm(decRm),
    .decImmValue(decImmValue), .rd1(rd1), .rd2(rd2), .wbValid(wbValid),
    .wbData(wbData), .wbReg(wbReg), .wbWrote(wbWrote), .wbFlags(wbFlags)
  );

  resultPort i_result (
    .clk(clk), .reset(reset), .wbValid(wbValid), .wbData(wbData), .wbReg(wbReg),
    .wbWrote(wbWrote), .wbFlags(wbFlags), .resultCredit(resultCredit),
    .advance(advance), .resultValid(resultValid), .resultData(resultData),
    .resultReg(resultReg), .resultWrote(resultWrote), .resultFlags(resultFlags)
  );

endmodule

/* bench/armliteModel.svh */
`ifndef ARMLITE_MODEL_SVH
`define ARMLITE_MODEL_SVH

localparam int ModelW = `ARMLITE_DATA_W;
localparam longint SignedMax = 64'sd2147483647;
localparam longint SignedMin = -64'sd2147483648;

typedef struct packed {
  logic [ModelW-1:0] data;
  regIdx_t           dest;
  logic              wrote;
  flags_t            flags;
} expRecord_t;

// Architectural state in program order
logic [ModelW-1:0] modelRegs [16];
flags_t            modelFlags;
expRecord_t        expQueue [$];

function automatic void resetModel();
  for (int i = 0; i < 16; i++) begin
    modelRegs[i] = '0;
  end
  modelFlags = '0;
  expQueue.delete();
endfunction

// Returns the carry out on top of the shifted value
function automatic logic [ModelW:0] modelShift(logic [ModelW-1:0] rm, shiftOp_t kind,
                                               logic [3:0] amt, logic carryIn);
  logic [2*ModelW-1:0] twice;
  logic [ModelW-1:0]   value;
  logic                carry;
  value = rm;
  carry = carryIn;
  if (amt != 4'd0) begin
    // Right shifts and rotates drop bit amt-1 last
    carry = rm[amt - 1];
    case (kind)
      SH_LSL: begin
        value = rm << amt;
        carry = rm[ModelW - amt];
      end
      SH_LSR: value = rm >> amt;
      SH_ASR: value = $signed(rm) >>> amt;
      default: begin
        twice = {rm, rm} >> amt;
        value = twice[ModelW-1:0];
      end
    endcase
  end
  return {carry, value};
endfunction

// Executes one instruction word and queues the record it should produce
function automatic void applyInstr(logic [ModelW-1:0] word);
  aluOp_t            op;
  regIdx_t           rd;
  logic [ModelW-1:0] a;
  logic [ModelW-1:0] b;
  logic [ModelW-1:0] res;
  logic [ModelW:0]   shifted;
  longint            wide;
  flags_t            f;
  expRecord_t        rec;
  op = aluOp_t'(word[`ARMLITE_F_OP]);
  rd = word[`ARMLITE_F_RD];
  a = modelRegs[word[`ARMLITE_F_RN]];
  f = modelFlags;
  if (word[`ARMLITE_F_IMMSEL]) begin
    b = '0;
    b[`ARMLITE_IMM_W-1:0] = word[`ARMLITE_F_IMM];
  end else begin
    shifted = modelShift(modelRegs[word[`ARMLITE_F_RM]],
                         shiftOp_t'(word[`ARMLITE_F_SHIFT]),
                         word[`ARMLITE_F_SHAMT], modelFlags.c);
    b = shifted[ModelW-1:0];
    f.c = shifted[ModelW];
  end
  res = '0;
  case (op)
    OP_AND: res = a & b;
    OP_EOR: res = a ^ b;
    OP_ORR: res = a | b;
    OP_MOV: res = b;
    OP_MVN: res = ~b;
    OP_ADD: begin
      res = a + b;
      wide = longint'(a) + longint'(b);
      f.c = (wide > 64'sh0_FFFF_FFFF);
      wide = longint'($signed(a)) + longint'($signed(b));
      f.v = (wide > SignedMax) || (wide < SignedMin);
    end
    default: begin
      // SUB and CMP where carry means no borrow
      res = a - b;
      f.c = (a >= b);
      wide = longint'($signed(a)) - longint'($signed(b));
      f.v = (wide > SignedMax) || (wide < SignedMin);
    end
  endcase
  f.n = res[ModelW-1];
  f.z = (res == '0);
  if (word[`ARMLITE_F_SETFLAGS] || op == OP_CMP) begin
    modelFlags = f;
  end
  if (op != OP_CMP) begin
    modelRegs[rd] = res;
  end
  rec.data = res;
  rec.dest = rd;
  rec.wrote = (op != OP_CMP);
  rec.flags = modelFlags;
  expQueue.push_back(rec);
endfunction

`endif

/* bench/armliteTb.sv */
`timescale 1ns/10ps
`include "armlite_defs.svh"

module armliteTb import armlitePkg::*; ();
  localparam int W = `ARMLITE_DATA_W;
  localparam int NumInstr = 400;
  localparam int IntakeDepth = `ARMLITE_INTAKE_DEPTH;
  localparam int ResultCredits = `ARMLITE_RESULT_CREDITS;
  localparam int TimeoutCycles = NumInstr * 20;

  logic         clk;
  logic         reset;
  logic         instrValid;
  logic [W-1:0] instr;
  logic         instrCredit;
  logic         resultValid;
  logic [W-1:0] resultData;
  regIdx_t      resultReg;
  logic         resultWrote;
  flags_t       resultFlags;
  logic         resultCredit;

  logic [31:0]  rngState;
  logic [W-1:0] instrList [NumInstr];
  int           sentCount;
  int           received;
  int           senderCredits;
  int           rxCredits;
  int           cycleCount;
  int           creditDue [$];

  `include "armliteModel.svh"

  armliteCore i_dut (
    .clk(clk), .reset(reset), .instrValid(instrValid), .instr(instr),
    .instrCredit(instrCredit), .resultValid(resultValid), .resultData(resultData),
    .resultReg(resultReg), .resultWrote(resultWrote), .resultFlags(resultFlags),
    .resultCredit(resultCredit)
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] xorshift32(logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic logic [31:0] nextRandom();
    rngState = xorshift32(rngState);
    return rngState;
  endfunction

  task automatic abortRun(string reason);
    $display("%s", reason);
    $display("TB FAILED");
    $fatal(1, "armliteTb stopped");
  endtask

  task automatic checkData(logic [W-1:0] got, logic [W-1:0] exp, int idx);
    if (got !== exp) begin
      abortRun($sformatf("Mismatch at %0t: record %0d data 0x%08h, expected 0x%08h",
                         $time, idx, got, exp));
    end
  endtask

  task automatic checkReg(regIdx_t got, logic gotWrote, regIdx_t exp, logic expWrote,
                          int idx);
    if (got !== exp || gotWrote !== expWrote) begin
      abortRun($sformatf("Mismatch at %0t: record %0d reg %0d wrote %b, expected %0d wrote %b",
                         $time, idx, got, gotWrote, exp, expWrote));
    end
  endtask

  task automatic checkFlags(flags_t got, flags_t exp, int idx);
    if (got !== exp) begin
      abortRun($sformatf("Mismatch at %0t: record %0d flags NZCV %b, expected %b",
                         $time, idx, got, exp));
    end
  endtask

  task automatic buildProgram();
    logic [W-1:0] w;
    // Entry 0 reads r15 before anything writes it so the result is just the immediate
    w = nextRandom();
    instrList[0] = {1'b0, OP_ORR, 2'b01, SH_LSL, 4'd0, 4'd15, 4'd0, w[11:0]};
    for (int i = 1; i < 16; i++) begin
      w = nextRandom();
      instrList[i] = {1'b0, OP_MOV, 2'b01, SH_LSL, 4'd0, 4'd0, 4'(i), w[11:0]};
    end
    for (int i = 16; i < NumInstr; i++) begin
      w = nextRandom();
      // Half stay within r0..r3 so back-to-back dependencies are frequent
      if (nextRandom() % 2 == 0) begin
        w[19:18] = 2'b00;
        w[15:14] = 2'b00;
        w[3:2] = 2'b00;
      end
      instrList[i] = w;
    end
  endtask

  task automatic nextCycle();
    @(negedge clk);
    cycleCount++;
    if (cycleCount > TimeoutCycles) begin
      abortRun($sformatf("Timeout after %0d cycles with %0d of %0d records received",
                         cycleCount, received, NumInstr));
    end
  endtask

  task automatic watchOutputs();
    expRecord_t exp;
    if ((instrCredit || resultValid) && sentCount == 0) begin
      abortRun("Output activity appeared before any instruction was sent");
    end
    if (instrCredit) begin
      if (senderCredits >= IntakeDepth) begin
        abortRun("Intake returned a credit while the sender held all of its credits");
      end
      senderCredits++;
    end
    if (resultValid) begin
      if (expQueue.size() == 0) begin
        abortRun("Result record arrived with no expected record pending");
      end
      if (rxCredits == 0) begin
        abortRun("Result record arrived without a credit granted by the receiver");
      end
      rxCredits--;
      exp = expQueue.pop_front();
      checkData(resultData, exp.data, received);
      checkReg(resultReg, resultWrote, exp.dest, exp.wrote, received);
      checkFlags(resultFlags, exp.flags, received);
      received++;
      creditDue.push_back(cycleCount + int'(nextRandom() % 7));
    end
  endtask

  task automatic driveSender();
    instrValid = 1'b0;
    if (sentCount < NumInstr && senderCredits > 0 && nextRandom() % 4 != 0) begin
      instr = instrList[sentCount];
      instrValid = 1'b1;
      senderCredits--;
      applyInstr(instrList[sentCount]);
      sentCount++;
    end
  endtask

  // At most one credit pulse per cycle and later ones wait
  task automatic returnCredits();
    int slot;
    slot = -1;
    resultCredit = 1'b0;
    for (int k = 0; k < creditDue.size(); k++) begin
      if (slot < 0 && creditDue[k] <= cycleCount) begin
        slot = k;
      end
    end
    if (slot >= 0) begin
      creditDue.delete(slot);
      resultCredit = 1'b1;
      rxCredits++;
    end
  endtask

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    instrValid = 1'b0;
    instr = '0;
    resultCredit = 1'b0;
    rngState = 32'hb121;
    sentCount = 0;
    received = 0;
    senderCredits = IntakeDepth;
    rxCredits = ResultCredits;
    cycleCount = 0;
    resetModel();
    buildProgram();
    repeat (8) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    // Quiet stretch after reset
    repeat (6) begin
      nextCycle();
      watchOutputs();
    end
    while (received < NumInstr) begin
      nextCycle();
      watchOutputs();
      driveSender();
      returnCredits();
    end
    // Late credits and any stray record
    repeat (10) begin
      nextCycle();
      watchOutputs();
      driveSender();
      returnCredits();
    end
    if (expQueue.size() == 0 && senderCredits == IntakeDepth) begin
      $display("TB PASSED");
      $finish;
    end else begin
      abortRun($sformatf("Run ended with %0d records pending and %0d of %0d sender credits",
                         expQueue.size(), senderCredits, IntakeDepth));
    end
  end

endmodule

/* armlite.f */
+incdir+hdl
+incdir+bench
hdl/armlitePkg.sv
hdl/instrIntake.sv
hdl/regFile.sv
hdl/executeStage.sv
hdl/resultPort.sv
hdl/armliteCore.sv
bench/armliteTb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the armlite testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module armliteTb \
  -f armlite.f -o armliteSim \
  && ./obj_dir/armliteSim \
  || { echo "armlite simulation did not pass"; exit 1; }
